//--- hw/fc_pkg.sv
/*
 * FC engine shared definitions
 * Datapath widths, command and state encodings, requantization constants
 */
`default_nettype none

package fc_pkg;

  // Datapath widths, four int8 elements per stream word
  localparam int LANES  = 4;
  localparam int DATA_W = 32;
  localparam int ELEM_W = 8;
  localparam int ACC_W  = 28;

  // Requantization
  // Bias aligns at bit 6, positive results saturate from bit 13 up
  localparam int BIAS_SHIFT = 6;
  localparam int SAT_BIT    = 13;

  // Host commands
  typedef enum logic [1:0] {
    cmd_load_feat = 2'd0,
    cmd_load_bias = 2'd1,
    cmd_run       = 2'd2
  } fc_cmd_t;

  // Controller states
  typedef enum logic [2:0] {
    st_idle      = 3'd0,
    st_load_feat = 3'd1,
    st_load_bias = 3'd2,
    st_run       = 3'd3,
    st_flush     = 3'd4
  } fc_state_t;

endpackage

`default_nettype wire

//--- hw/fc_pe.sv
/*
 * FC processing element
 * Three-stage signed 8x8 multiply-accumulate with feature pass-through
 */
`timescale 1ns/1ps
`default_nettype none

module fc_pe (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic [fc_pkg::ELEM_W-1:0] in_feat,
  input  logic                      in_valid,
  input  logic                      in_first,
  input  logic                      in_last,
  input  logic [fc_pkg::ELEM_W-1:0] w,
  output logic [fc_pkg::ELEM_W-1:0] out_feat,
  output logic                      out_valid,
  output logic                      out_first,
  output logic                      out_last,
  output logic [fc_pkg::ACC_W-1:0]  acc,
  output logic                      acc_valid
);

  localparam int PROD_W = 2 * fc_pkg::ELEM_W;

  logic [fc_pkg::ELEM_W-1:0] mag_a;
  logic [fc_pkg::ELEM_W-1:0] mag_w;
  logic [PROD_W-1:0]         mag_q;
  logic                      sign_q;
  logic [PROD_W-1:0]         prod_q;
  logic [fc_pkg::ACC_W-1:0]  prod_ext;
  logic                      v1, f1, l1;
  logic                      v2, f2, l2;

  // Magnitudes, -128 maps to 8'h80 read as unsigned
  assign mag_a = in_feat[fc_pkg::ELEM_W-1] ? -in_feat : in_feat;
  assign mag_w = w[fc_pkg::ELEM_W-1] ? -w : w;
  assign prod_ext = {{(fc_pkg::ACC_W - PROD_W){prod_q[PROD_W-1]}}, prod_q};

  always_ff @(posedge clk) begin
    // Systolic pass-through
    out_feat  <= in_feat;
    out_first <= in_first;
    out_last  <= in_last;
    // Stage 1 unsigned product and sign
    mag_q  <= mag_a * mag_w;
    sign_q <= in_feat[fc_pkg::ELEM_W-1] ^ w[fc_pkg::ELEM_W-1];
    f1     <= in_first;
    l1     <= in_last;
    // Stage 2 signed product
    prod_q <= sign_q ? -mag_q : mag_q;
    f2     <= f1;
    l2     <= l1;
    // Stage 3 accumulate, wraps at ACC_W
    if (v2)
      acc <= f2 ? prod_ext : acc + prod_ext;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
      v1        <= 1'b0;
      v2        <= 1'b0;
      acc_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
      v1        <= in_valid;
      v2        <= v1;
      acc_valid <= v2 & l2;
    end
  end

  // Every dot product spans more than one element
  a_first_last: assert property (@(posedge clk) disable iff (!rstn)
    in_valid |-> !(in_first && in_last));

endmodule

`default_nettype wire

//--- hw/fc_ctrl.sv
/*
 * FC engine controller
 * Decodes host commands, counts load words and run beats, drives s_ready
 */
`timescale 1ns/1ps
`default_nettype none

module fc_ctrl #(
  parameter int FEAT_DEPTH  = 1024,
  parameter int GROUP_DEPTH = 256,
  localparam int MAX_CNT = (FEAT_DEPTH > fc_pkg::LANES * GROUP_DEPTH) ?
                           FEAT_DEPTH : fc_pkg::LANES * GROUP_DEPTH,
  localparam int SIZE_W  = $clog2(MAX_CNT + 1),
  localparam int ADDR_W  = $clog2(MAX_CNT / fc_pkg::LANES),
  localparam int IDX_W   = $clog2(FEAT_DEPTH)
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic                start,
  input  fc_pkg::fc_cmd_t     cmd,
  input  logic [SIZE_W-1:0]   size,
  input  logic                s_valid,
  input  logic                held_full,
  input  logic                run_end,
  output logic                s_ready,
  output logic                feat_we,
  output logic                bias_we,
  output logic [ADDR_W-1:0]   wr_addr,
  output logic                beat,
  output logic [IDX_W-1:0]    elem,
  output logic                first,
  output logic                last,
  output logic                run_start
);

  localparam int GRP_W = $clog2(GROUP_DEPTH);

  fc_pkg::fc_state_t  state;
  logic [ADDR_W-1:0]  wcnt;
  logic [ADDR_W-1:0]  last_word;
  logic [IDX_W-1:0]   last_elem;
  logic [GRP_W-1:0]   grp;
  logic [GRP_W-1:0]   last_grp;
  logic               xfer;
  logic               accept;

  assign xfer   = s_valid & s_ready;
  assign accept = start && (state == fc_pkg::st_idle);

  // Loads take every word, a run stalls while the drain holds a word
  always_comb begin
    case (state)
      fc_pkg::st_load_feat,
      fc_pkg::st_load_bias: s_ready = 1'b1;
      fc_pkg::st_run:       s_ready = !held_full;
      default:              s_ready = 1'b0;
    endcase
  end

  assign feat_we   = xfer && (state == fc_pkg::st_load_feat);
  assign bias_we   = xfer && (state == fc_pkg::st_load_bias);
  assign wr_addr   = wcnt;
  assign beat      = xfer && (state == fc_pkg::st_run);
  assign first     = (elem == '0);
  assign last      = (elem == last_elem);
  assign run_start = accept && (cmd == fc_pkg::cmd_run);

  // Sizes captured with the command
  always_ff @(posedge clk) begin
    if (accept) begin
      last_word <= ADDR_W'((size >> 2) - 1'b1);
      if (cmd == fc_pkg::cmd_load_feat)
        last_elem <= IDX_W'(size - 1'b1);
      if (cmd == fc_pkg::cmd_load_bias)
        last_grp <= GRP_W'((size >> 2) - 1'b1);
    end
  end

  //////////////////////////////////////////////////
  // Command FSM and counters
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= fc_pkg::st_idle;
      wcnt  <= '0;
      elem  <= '0;
      grp   <= '0;
    end else begin
      case (state)
        fc_pkg::st_idle: begin
          if (start) begin
            wcnt <= '0;
            elem <= '0;
            grp  <= '0;
            case (cmd)
              fc_pkg::cmd_load_feat: state <= fc_pkg::st_load_feat;
              fc_pkg::cmd_load_bias: state <= fc_pkg::st_load_bias;
              fc_pkg::cmd_run:       state <= fc_pkg::st_run;
              default:               state <= fc_pkg::st_idle;
            endcase
          end
        end
        fc_pkg::st_load_feat,
        fc_pkg::st_load_bias: begin
          if (xfer) begin
            wcnt <= wcnt + 1'b1;
            if (wcnt == last_word)
              state <= fc_pkg::st_idle;
          end
        end
        fc_pkg::st_run: begin
          if (xfer) begin
            if (last) begin
              elem <= '0;
              grp  <= grp + 1'b1;
              // Last weight of the last group, wait for the output side
              if (grp == last_grp)
                state <= fc_pkg::st_flush;
            end else begin
              elem <= elem + 1'b1;
            end
          end
        end
        fc_pkg::st_flush: begin
          if (run_end)
            state <= fc_pkg::st_idle;
        end
        default: state <= fc_pkg::st_idle;
      endcase
    end
  end

  // Host only issues commands to an idle engine
  a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
    start |-> state == fc_pkg::st_idle);

endmodule

`default_nettype wire

//--- hw/fc_feeder.sv
/*
 * FC feature feeder
 * Holds the feature memory, presents one element per weight beat
 * and skews the weight lanes to meet the systolic feature chain
 */
`timescale 1ns/1ps
`default_nettype none

module fc_feeder #(
  parameter int FEAT_DEPTH = 1024,
  localparam int FA_W  = $clog2(FEAT_DEPTH / fc_pkg::LANES),
  localparam int IDX_W = $clog2(FEAT_DEPTH)
) (
  input  logic                                          clk,
  input  logic                                          rstn,
  input  logic [fc_pkg::DATA_W-1:0]                     s_data,
  input  logic                                          feat_we,
  input  logic [FA_W-1:0]                               wr_addr,
  input  logic                                          beat,
  input  logic [IDX_W-1:0]                              elem,
  input  logic                                          first,
  input  logic                                          last,
  output logic [fc_pkg::ELEM_W-1:0]                     feat,
  output logic                                          feat_valid,
  output logic                                          feat_first,
  output logic                                          feat_last,
  output logic [fc_pkg::LANES-1:0][fc_pkg::ELEM_W-1:0]  lane_w
);

  localparam int SEL_W = $clog2(fc_pkg::LANES);

  logic [fc_pkg::DATA_W-1:0]                     feat_mem [FEAT_DEPTH / fc_pkg::LANES];
  logic [fc_pkg::DATA_W-1:0]                     rd_word;
  logic [SEL_W-1:0]                              rd_sel;
  logic [fc_pkg::LANES-1:0][fc_pkg::DATA_W-1:0]  w_dly;

  // Feature word write, and read of the word holding elem
  always_ff @(posedge clk) begin
    if (feat_we)
      feat_mem[wr_addr] <= s_data;
    rd_word    <= feat_mem[elem[IDX_W-1:SEL_W]];
    rd_sel     <= elem[SEL_W-1:0];
    feat_first <= first;
    feat_last  <= last;
  end

  always_ff @(posedge clk) begin
    if (!rstn)
      feat_valid <= 1'b0;
    else
      feat_valid <= beat;
  end

  assign feat = rd_word[rd_sel*fc_pkg::ELEM_W +: fc_pkg::ELEM_W];

  // Weight word delay line, lane i taps stage i
  always_ff @(posedge clk) begin
    w_dly[0] <= s_data;
    for (int i = 1; i < fc_pkg::LANES; i++)
      w_dly[i] <= w_dly[i-1];
  end

  always_comb begin
    for (int i = 0; i < fc_pkg::LANES; i++)
      lane_w[i] = w_dly[i][i*fc_pkg::ELEM_W +: fc_pkg::ELEM_W];
  end

endmodule

`default_nettype wire

//--- hw/fc_drain.sv
/*
 * FC result drain
 * Bias add, ReLU requantization with saturation, output word
 * hand-off and running argmax over the outputs of a run
 */
`timescale 1ns/1ps
`default_nettype none

module fc_drain #(
  parameter int GROUP_DEPTH = 256,
  localparam int GRP_W  = $clog2(GROUP_DEPTH),
  localparam int AMAX_W = GRP_W + $clog2(fc_pkg::LANES)
) (
  input  logic                                         clk,
  input  logic                                         rstn,
  input  logic [fc_pkg::DATA_W-1:0]                    s_data,
  input  logic                                         bias_we,
  input  logic [GRP_W-1:0]                             wr_addr,
  input  logic                                         run_start,
  input  logic [fc_pkg::LANES-1:0][fc_pkg::ACC_W-1:0]  acc,
  input  logic [fc_pkg::LANES-1:0]                     acc_valid,
  input  logic                                         m_ready,
  output logic                                         m_valid,
  output logic [fc_pkg::DATA_W-1:0]                    m_data,
  output logic                                         m_last,
  output logic                                         held_full,
  output logic                                         run_end,
  output logic                                         done,
  output logic [AMAX_W-1:0]                            argmax
);

  localparam int SEL_W = $clog2(fc_pkg::LANES);
  localparam int PAD_W = fc_pkg::ACC_W - fc_pkg::ELEM_W - fc_pkg::BIAS_SHIFT;
  localparam int Q_W   = fc_pkg::SAT_BIT - fc_pkg::BIAS_SHIFT;

  logic [fc_pkg::DATA_W-1:0]                     bias_mem [GROUP_DEPTH];
  logic [fc_pkg::DATA_W-1:0]                     bias_q;
  logic [GRP_W-1:0]                              grp;
  logic [GRP_W-1:0]                              last_grp;
  logic [fc_pkg::LANES-1:0][fc_pkg::ACC_W-1:0]   sum_q;
  logic [fc_pkg::LANES-1:0][fc_pkg::ACC_W-1:0]   biased;
  logic [fc_pkg::LANES-1:0][fc_pkg::ELEM_W-1:0]  q;
  logic                                          pend;
  logic [fc_pkg::ELEM_W-1:0]                     max_val;
  logic [fc_pkg::ELEM_W-1:0]                     nxt_max;
  logic [AMAX_W-1:0]                             nxt_arg;

  // Bias words, the highest written index marks the last group
  always_ff @(posedge clk) begin
    if (bias_we) begin
      bias_mem[wr_addr] <= s_data;
      last_grp          <= wr_addr;
    end
    bias_q <= bias_mem[grp];
  end

  // Lane sums, lane 3 closes the group
  always_ff @(posedge clk) begin
    for (int i = 0; i < fc_pkg::LANES; i++)
      if (acc_valid[i])
        sum_q[i] <= acc[i];
  end

  always_ff @(posedge clk) begin
    if (!rstn)
      pend <= 1'b0;
    else
      pend <= acc_valid[fc_pkg::LANES-1];
  end

  //////////////////////////////////////////////////
  // Bias add and requantization
  //////////////////////////////////////////////////
  always_comb begin
    logic [fc_pkg::ELEM_W-1:0] b;
    for (int i = 0; i < fc_pkg::LANES; i++) begin
      b = bias_q[i*fc_pkg::ELEM_W +: fc_pkg::ELEM_W];
      biased[i] = sum_q[i] + {{PAD_W{b[fc_pkg::ELEM_W-1]}}, b, {fc_pkg::BIAS_SHIFT{1'b0}}};
      if (biased[i][fc_pkg::ACC_W-1])
        q[i] = '0;
      else if (|biased[i][fc_pkg::ACC_W-2:fc_pkg::SAT_BIT])
        q[i] = {1'b0, {Q_W{1'b1}}};
      else
        q[i] = {1'b0, biased[i][fc_pkg::SAT_BIT-1:fc_pkg::BIAS_SHIFT]};
    end
  end

  // First largest wins, lanes scanned in index order
  always_comb begin
    nxt_max = max_val;
    nxt_arg = argmax;
    for (int i = 0; i < fc_pkg::LANES; i++) begin
      if (q[i] > nxt_max) begin
        nxt_max = q[i];
        nxt_arg = {grp, SEL_W'(i)};
      end
    end
  end

  //////////////////////////////////////////////////
  // Output word and run bookkeeping
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (pend)
      m_data <= q;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
      grp     <= '0;
      max_val <= '0;
      argmax  <= '0;
    end else if (run_start) begin
      grp     <= '0;
      max_val <= '0;
      argmax  <= '0;
    end else if (pend) begin
      m_valid <= 1'b1;
      m_last  <= (grp == last_grp);
      grp     <= grp + 1'b1;
      max_val <= nxt_max;
      argmax  <= nxt_arg;
    end else if (m_valid && m_ready) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end
  end

  assign held_full = m_valid;
  assign run_end   = m_valid & m_ready & m_last;
  assign done      = run_end;

  // Input stall must keep a new word from landing on a held one
  a_no_overwrite: assert property (@(posedge clk) disable iff (!rstn)
    pend |-> !m_valid || m_ready);

endmodule

`default_nettype wire

//--- hw/fc_core.sv
/*
 * FC layer engine top level
 * Controller, feature feeder, systolic PE chain and result drain
 */
`timescale 1ns/1ps
`default_nettype none

module fc_core #(
  parameter int FEAT_DEPTH  = 1024,
  parameter int GROUP_DEPTH = 256,
  localparam int MAX_CNT = (FEAT_DEPTH > fc_pkg::LANES * GROUP_DEPTH) ?
                           FEAT_DEPTH : fc_pkg::LANES * GROUP_DEPTH,
  localparam int SIZE_W  = $clog2(MAX_CNT + 1),
  localparam int AMAX_W  = $clog2(GROUP_DEPTH) + $clog2(fc_pkg::LANES)
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      start,
  input  fc_pkg::fc_cmd_t           cmd,
  input  logic [SIZE_W-1:0]         size,
  input  logic                      s_valid,
  input  logic [fc_pkg::DATA_W-1:0] s_data,
  output logic                      s_ready,
  output logic                      m_valid,
  output logic [fc_pkg::DATA_W-1:0] m_data,
  output logic                      m_last,
  input  logic                      m_ready,
  output logic                      done,
  output logic [AMAX_W-1:0]         argmax
);

  localparam int ADDR_W = $clog2(MAX_CNT / fc_pkg::LANES);
  localparam int FA_W   = $clog2(FEAT_DEPTH / fc_pkg::LANES);
  localparam int GRP_W  = $clog2(GROUP_DEPTH);
  localparam int IDX_W  = $clog2(FEAT_DEPTH);

  logic                                          feat_we;
  logic                                          bias_we;
  logic [ADDR_W-1:0]                             wr_addr;
  logic                                          beat;
  logic [IDX_W-1:0]                              elem;
  logic                                          first;
  logic                                          last;
  logic                                          run_start;
  logic                                          held_full;
  logic                                          run_end;

  // Feature chain, entry i feeds element i
  logic [fc_pkg::LANES:0][fc_pkg::ELEM_W-1:0]    chain_feat;
  logic [fc_pkg::LANES:0]                        chain_valid;
  logic [fc_pkg::LANES:0]                        chain_first;
  logic [fc_pkg::LANES:0]                        chain_last;
  logic [fc_pkg::LANES-1:0][fc_pkg::ELEM_W-1:0]  lane_w;
  logic [fc_pkg::LANES-1:0][fc_pkg::ACC_W-1:0]   lane_acc;
  logic [fc_pkg::LANES-1:0]                      lane_acc_valid;

  fc_ctrl #(
    .FEAT_DEPTH  (FEAT_DEPTH),
    .GROUP_DEPTH (GROUP_DEPTH)
  ) u_ctrl (
    .clk       (clk),
    .rstn      (rstn),
    .start     (start),
    .cmd       (cmd),
    .size      (size),
    .s_valid   (s_valid),
    .held_full (held_full),
    .run_end   (run_end),
    .s_ready   (s_ready),
    .feat_we   (feat_we),
    .bias_we   (bias_we),
    .wr_addr   (wr_addr),
    .beat      (beat),
    .elem      (elem),
    .first     (first),
    .last      (last),
    .run_start (run_start)
  );

  fc_feeder #(
    .FEAT_DEPTH (FEAT_DEPTH)
  ) u_feeder (
    .clk        (clk),
    .rstn       (rstn),
    .s_data     (s_data),
    .feat_we    (feat_we),
    .wr_addr    (wr_addr[FA_W-1:0]),
    .beat       (beat),
    .elem       (elem),
    .first      (first),
    .last       (last),
    .feat       (chain_feat[0]),
    .feat_valid (chain_valid[0]),
    .feat_first (chain_first[0]),
    .feat_last  (chain_last[0]),
    .lane_w     (lane_w)
  );

  //////////////////////////////////////////////////
  // Systolic PE chain
  //////////////////////////////////////////////////
  for (genvar i = 0; i < fc_pkg::LANES; i++) begin : g_pe
    fc_pe u_pe (
      .clk       (clk),
      .rstn      (rstn),
      .in_feat   (chain_feat[i]),
      .in_valid  (chain_valid[i]),
      .in_first  (chain_first[i]),
      .in_last   (chain_last[i]),
      .w         (lane_w[i]),
      .out_feat  (chain_feat[i+1]),
      .out_valid (chain_valid[i+1]),
      .out_first (chain_first[i+1]),
      .out_last  (chain_last[i+1]),
      .acc       (lane_acc[i]),
      .acc_valid (lane_acc_valid[i])
    );
  end

  fc_drain #(
    .GROUP_DEPTH (GROUP_DEPTH)
  ) u_drain (
    .clk       (clk),
    .rstn      (rstn),
    .s_data    (s_data),
    .bias_we   (bias_we),
    .wr_addr   (wr_addr[GRP_W-1:0]),
    .run_start (run_start),
    .acc       (lane_acc),
    .acc_valid (lane_acc_valid),
    .m_ready   (m_ready),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_last    (m_last),
    .held_full (held_full),
    .run_end   (run_end),
    .done      (done),
    .argmax    (argmax)
  );

endmodule

`default_nettype wire

//--- tests/fc_model.svh
/*
 * FC layer reference model
 * Wrapped dot products, bias add with ReLU and saturation, argmax
 */
`ifndef FC_MODEL_SVH
`define FC_MODEL_SVH

// Model copies of what the engine holds or receives
logic signed [7:0] ref_feat [N_IN];
logic signed [7:0] ref_bias [N_OUT];
logic signed [7:0] ref_w    [N_OUT][N_IN];
logic        [7:0] ref_out  [N_OUT];

// Dot product of one neuron, wraps at 28 bits
function automatic logic [27:0] dot_product(input int o);
  logic [27:0]        sum;
  logic signed [15:0] p;
  sum = '0;
  for (int e = 0; e < N_IN; e++) begin
    p = ref_feat[e] * ref_w[o][e];
    sum = sum + {{12{p[15]}}, p};
  end
  return sum;
endfunction

// Bias aligned at bit 6, ReLU, saturation from 2^13 up
function automatic logic [7:0] requantize(input logic [27:0] acc,
                                          input logic signed [7:0] bias);
  logic [27:0] v;
  v = acc + {{14{bias[7]}}, bias, 6'b0};
  if (v[27])
    return 8'd0;
  if (v >= 28'd8192)
    return 8'd127;
  return {1'b0, v[12:6]};
endfunction

function automatic void compute_outputs();
  for (int o = 0; o < N_OUT; o++)
    ref_out[o] = requantize(dot_product(o), ref_bias[o]);
endfunction

// First index of the largest output
function automatic int first_argmax();
  int best;
  best = 0;
  for (int o = 1; o < N_OUT; o++)
    if (ref_out[o] > ref_out[best])
      best = o;
  return best;
endfunction

`endif

//--- tests/tb_fc_core.sv
/*
 * Testbench for the FC layer engine
 * Random features, biases and weights against a reference model,
 * with output back-pressure and saturating weight patterns
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fc_core;

  localparam int N_IN    = 32;
  localparam int N_OUT   = 8;
  localparam int N_GRP   = N_OUT / 4;
  localparam int TIMEOUT = 2000;

  logic            clk;
  logic            rstn;
  logic            start;
  fc_pkg::fc_cmd_t cmd;
  logic [10:0]     size;
  logic            s_valid;
  logic [31:0]     s_data;
  logic            s_ready;
  logic            m_valid;
  logic [31:0]     m_data;
  logic            m_last;
  logic            m_ready;
  logic            done;
  logic [9:0]      argmax;

  logic [31:0] lcg_state;
  logic [31:0] in_words[$];
  bit          in_gaps[$];
  logic [7:0]  got_out [N_OUT];
  int          checks;
  int          errors;
  int          timeouts;

  `include "fc_model.svh"

  fc_core #(
    .FEAT_DEPTH  (1024),
    .GROUP_DEPTH (256)
  ) i_dut (
    .clk     (clk),
    .rstn    (rstn),
    .start   (start),
    .cmd     (cmd),
    .size    (size),
    .s_valid (s_valid),
    .s_data  (s_data),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_last  (m_last),
    .m_ready (m_ready),
    .done    (done),
    .argmax  (argmax)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string test, input string what, input int idx,
                             input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s %s[%0d] expected %0h actual %0h", test, what, idx, exp, got);
    end
  endtask

  // Queue a word, with a random idle cycle in front of it now and then
  function automatic void push_word(input logic [31:0] w);
    logic [31:0] r;
    r = next_rand();
    in_words.push_back(w);
    in_gaps.push_back(r[27:25] == 3'd0);
  endfunction

  task automatic issue_cmd(input fc_pkg::fc_cmd_t c, input logic [10:0] n);
    @(posedge clk);
    start <= 1'b1;
    cmd   <= c;
    size  <= n;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic stream_words();
    logic [31:0] w;
    bit          gap;
    int          wait_cnt;
    while (in_words.size() > 0) begin
      w   = in_words.pop_front();
      gap = in_gaps.pop_front();
      if (gap) begin
        s_valid <= 1'b0;
        @(posedge clk);
      end
      s_valid <= 1'b1;
      s_data  <= w;
      wait_cnt = 0;
      @(posedge clk);
      while (!s_ready && wait_cnt < TIMEOUT) begin
        @(posedge clk);
        wait_cnt++;
      end
      if (!s_ready) begin
        timeouts++;
        $display("Timeout: input stream stalled with %0d words left", in_words.size() + 1);
        in_words.delete();
        in_gaps.delete();
      end
    end
    s_valid <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Output side scoreboard
  //////////////////////////////////////////////////
  task automatic collect_outputs(input string test, input bit stall);
    logic [31:0] r;
    logic [31:0] exp_word;
    int          n_words;
    int          n_done;
    int          wait_cnt;
    n_words  = 0;
    n_done   = 0;
    wait_cnt = 0;
    while (n_words < N_GRP && wait_cnt < TIMEOUT) begin
      @(posedge clk);
      wait_cnt++;
      if (m_valid && m_ready) begin
        for (int i = 0; i < 4; i++) begin
          exp_word[8*i +: 8] = ref_out[4*n_words + i];
          got_out[4*n_words + i] = m_data[8*i +: 8];
        end
        check_value(test, "word", n_words, exp_word, m_data);
        check_value(test, "m_last", n_words, n_words == N_GRP - 1, m_last);
        n_words++;
        wait_cnt = 0;
      end
      if (done) begin
        n_done++;
        check_value(test, "argmax", n_done, first_argmax(), argmax);
      end
      // Ready high about three cycles in four
      if (stall) begin
        r = next_rand();
        m_ready <= (r[31:30] != 2'b00);
      end
    end
    if (n_words < N_GRP) begin
      timeouts++;
      $display("Timeout: %s received %0d of %0d output words", test, n_words, N_GRP);
    end
    m_ready <= 1'b1;
    // No extra word and no second done after the run
    for (int c = 0; c < 16; c++) begin
      @(posedge clk);
      check_value(test, "idle m_valid", c, 0, m_valid);
      if (done)
        n_done++;
    end
    check_value(test, "done pulses", 0, 1, n_done);
  endtask

  task automatic load_features();
    logic [31:0] r;
    for (int e = 0; e < N_IN; e++) begin
      r = next_rand();
      ref_feat[e] = r[23:16];
    end
    for (int k = 0; k < N_IN / 4; k++)
      push_word({ref_feat[4*k+3], ref_feat[4*k+2], ref_feat[4*k+1], ref_feat[4*k]});
    issue_cmd(fc_pkg::cmd_load_feat, N_IN);
    stream_words();
  endtask

  task automatic load_biases();
    logic [31:0] r;
    for (int o = 0; o < N_OUT; o++) begin
      r = next_rand();
      ref_bias[o] = r[23:16];
    end
    for (int g = 0; g < N_GRP; g++)
      push_word({ref_bias[4*g+3], ref_bias[4*g+2], ref_bias[4*g+1], ref_bias[4*g]});
    issue_cmd(fc_pkg::cmd_load_bias, N_OUT);
    stream_words();
  endtask

  // Saturating weights push even neurons up and odd neurons down
  task automatic run_layer(input string test, input bit saturate, input bit stall);
    logic [31:0] r;
    for (int o = 0; o < N_OUT; o++) begin
      for (int e = 0; e < N_IN; e++) begin
        r = next_rand();
        if (!saturate)
          ref_w[o][e] = r[23:16];
        else if ((o % 2 == 0) == (ref_feat[e] >= 0))
          ref_w[o][e] = 8'h7f;
        else
          ref_w[o][e] = 8'h80;
      end
    end
    compute_outputs();
    for (int g = 0; g < N_GRP; g++)
      for (int e = 0; e < N_IN; e++)
        push_word({ref_w[4*g+3][e], ref_w[4*g+2][e], ref_w[4*g+1][e], ref_w[4*g][e]});
    issue_cmd(fc_pkg::cmd_run, 11'd0);
    fork
      stream_words();
      collect_outputs(test, stall);
    join
    if (saturate)
      for (int o = 0; o < N_OUT; o++)
        check_value(test, "saturated byte", o, (o % 2 == 0) ? 127 : 0, got_out[o]);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    clk       = 1'b0;
    rstn      = 1'b0;
    start     = 1'b0;
    cmd       = fc_pkg::cmd_load_feat;
    size      = '0;
    s_valid   = 1'b0;
    s_data    = '0;
    m_ready   = 1'b1;
    lcg_state = 32'h9c21_62c1;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    repeat (16) @(posedge clk);
    rstn <= 1'b1;
    for (int c = 0; c < 4; c++) begin
      @(posedge clk);
      check_value("reset", "s_ready", c, 0, s_ready);
      check_value("reset", "m_valid", c, 0, m_valid);
      check_value("reset", "done", c, 0, done);
    end
    load_features();
    load_biases();
    run_layer("random", 1'b0, 1'b0);
    // Stored features and biases reused from here on
    run_layer("backpressure", 1'b0, 1'b1);
    run_layer("saturate", 1'b1, 1'b0);
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+tests
hw/fc_pkg.sv
hw/fc_pe.sv
hw/fc_ctrl.sv
hw/fc_feeder.sv
hw/fc_drain.sv
hw/fc_core.sv
tests/tb_fc_core.sv
